/* hdl/id_isa_pkg.sv */
//////////////////////////////
// RV32I encoding used by the decode stage
// Opcodes, function codes and the two views of an instruction word
//////////////////////////////

package id_isa_pkg;

  // Data path width
  localparam int XLEN = 32;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 values
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // R layout, also carries the I and U immediate bits
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // S layout, immediate split around the register fields
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    s_fmt_t s_fmt;
  } instr_u;

endpackage

/* hdl/id_ctrl_pkg.sv */
//////////////////////////////
// Decoded control word and the structs that link
// the decode stage to fetch and execute
//////////////////////////////

package id_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_EQ, ALU_NE
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_U} imm_sel_e;
  typedef enum logic       {WB_EX, WB_LSU} wb_sel_e;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_sel_e   imm_sel;
    logic       rf_we;
    wb_sel_e    wb_sel;
    logic       data_req;
    logic       data_we;
    logic       branch;
    logic       illegal;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
  } dec_t;

  // From fetch, instr_new is high in the first cycle of an instruction
  typedef struct packed {
    logic                          valid;
    logic                          instr_new;
    logic [id_isa_pkg::XLEN-1:0]   pc;
    id_isa_pkg::instr_u            instr;
  } fetch_t;

  typedef struct packed {
    alu_op_e                       alu_op;
    logic [id_isa_pkg::XLEN-1:0]   operand_a;
    logic [id_isa_pkg::XLEN-1:0]   operand_b;
  } alu_req_t;

  // Address comes from the ALU result
  typedef struct packed {
    logic                          req;
    logic                          we;
    logic [id_isa_pkg::XLEN-1:0]   wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                          ex_valid;
    logic                          lsu_valid;
    logic [id_isa_pkg::XLEN-1:0]   ex_result;
    logic [id_isa_pkg::XLEN-1:0]   lsu_rdata;
  } ex_rsp_t;

endpackage

/* hdl/id_decoder.sv */
//////////////////////////////
// Instruction decoder for the RV32I subset
// Turns an instruction word into the control word
//////////////////////////////

`timescale 1ns/1ns

module id_decoder #(
  parameter int NumRegs = 32
) (
  input  id_isa_pkg::instr_u instr_i,
  input  logic               first_cycle_i,
  output id_ctrl_pkg::dec_t  dec_o
);

  localparam logic [5:0] RegLimit = 6'(NumRegs);

  id_ctrl_pkg::dec_t dec;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              f3_alu_ok;
  logic              use_rs1;
  logic              use_rs2;
  logic              bad_reg;

  // Shared by OP and OP-IMM
  function automatic id_ctrl_pkg::alu_op_e f3_to_alu(input logic [2:0] f3);
    case (f3)
      id_isa_pkg::F3_SLT: return id_ctrl_pkg::ALU_SLT;
      id_isa_pkg::F3_XOR: return id_ctrl_pkg::ALU_XOR;
      id_isa_pkg::F3_OR:  return id_ctrl_pkg::ALU_OR;
      id_isa_pkg::F3_AND: return id_ctrl_pkg::ALU_AND;
      default:            return id_ctrl_pkg::ALU_ADD;
    endcase
  endfunction

  assign funct3    = instr_i.r_fmt.funct3;
  assign funct7    = instr_i.r_fmt.funct7;
  assign f3_alu_ok = funct3 inside {id_isa_pkg::F3_ADD_SUB, id_isa_pkg::F3_SLT,
                                    id_isa_pkg::F3_XOR, id_isa_pkg::F3_OR, id_isa_pkg::F3_AND};

  always_comb begin
    dec         = '0;
    dec.rs1     = instr_i.r_fmt.rs1;
    dec.rs2     = instr_i.r_fmt.rs2;
    dec.rd      = instr_i.r_fmt.rd;
    use_rs1     = 1'b1;
    use_rs2     = 1'b0;

    case (instr_i.r_fmt.opcode)
      id_isa_pkg::OPC_OP: begin
        use_rs2     = 1'b1;
        dec.rf_we   = 1'b1;
        dec.alu_op  = (funct7 == id_isa_pkg::F7_SUB) ? id_ctrl_pkg::ALU_SUB : f3_to_alu(funct3);
        dec.illegal = !f3_alu_ok ||
                      !((funct7 == id_isa_pkg::F7_BASE) ||
                        (funct7 == id_isa_pkg::F7_SUB && funct3 == id_isa_pkg::F3_ADD_SUB));
      end
      id_isa_pkg::OPC_OP_IMM: begin
        dec.rf_we    = 1'b1;
        dec.op_b_sel = id_ctrl_pkg::OP_B_IMM;
        dec.alu_op   = f3_to_alu(funct3);
        dec.illegal  = !f3_alu_ok;
      end
      id_isa_pkg::OPC_LUI: begin
        // Zero plus the upper immediate
        use_rs1      = 1'b0;
        dec.rf_we    = 1'b1;
        dec.op_a_sel = id_ctrl_pkg::OP_A_ZERO;
        dec.op_b_sel = id_ctrl_pkg::OP_B_IMM;
        dec.imm_sel  = id_ctrl_pkg::IMM_U;
      end
      id_isa_pkg::OPC_LOAD: begin
        dec.rf_we    = 1'b1;
        dec.wb_sel   = id_ctrl_pkg::WB_LSU;
        dec.data_req = 1'b1;
        dec.op_b_sel = id_ctrl_pkg::OP_B_IMM;
        dec.illegal  = funct3 != id_isa_pkg::F3_LW;
      end
      id_isa_pkg::OPC_STORE: begin
        use_rs2      = 1'b1;
        dec.data_req = 1'b1;
        dec.data_we  = 1'b1;
        dec.op_b_sel = id_ctrl_pkg::OP_B_IMM;
        dec.imm_sel  = id_ctrl_pkg::IMM_S;
        dec.illegal  = funct3 != id_isa_pkg::F3_SW;
      end
      id_isa_pkg::OPC_BRANCH: begin
        use_rs2     = 1'b1;
        dec.branch  = 1'b1;
        dec.illegal = !(funct3 inside {id_isa_pkg::F3_BEQ, id_isa_pkg::F3_BNE});
        if (first_cycle_i) begin
          // Compare rs1 against rs2
          dec.alu_op = (funct3 == id_isa_pkg::F3_BNE) ? id_ctrl_pkg::ALU_NE : id_ctrl_pkg::ALU_EQ;
        end else begin
          // Target address pc + B immediate
          dec.op_a_sel = id_ctrl_pkg::OP_A_PC;
          dec.op_b_sel = id_ctrl_pkg::OP_B_IMM;
          dec.imm_sel  = id_ctrl_pkg::IMM_B;
        end
      end
      default: begin
        use_rs1     = 1'b0;
        dec.illegal = 1'b1;
      end
    endcase

    // Register index beyond the implemented file
    bad_reg = (use_rs1 && {1'b0, dec.rs1} >= RegLimit) ||
              (use_rs2 && {1'b0, dec.rs2} >= RegLimit) ||
              (dec.rf_we && {1'b0, dec.rd} >= RegLimit);
    if (bad_reg) begin
      dec.illegal = 1'b1;
    end

    // Illegal words never reach the LSU or the branch logic
    if (dec.illegal) begin
      dec.data_req = 1'b0;
      dec.data_we  = 1'b0;
      dec.branch   = 1'b0;
    end
  end

  assign dec_o = dec;

endmodule

/* hdl/id_operand_mux.sv */
//////////////////////////////
// Immediate generation and operand selection
// Feeds the ALU request and the store data
//////////////////////////////

`timescale 1ns/1ns

module id_operand_mux (
  input  id_isa_pkg::instr_u               instr_i,
  input  id_ctrl_pkg::dec_t                dec_i,
  input  logic [id_isa_pkg::XLEN-1:0]      pc_i,
  input  logic [id_isa_pkg::XLEN-1:0]      rdata_a_i,
  input  logic [id_isa_pkg::XLEN-1:0]      rdata_b_i,
  output id_ctrl_pkg::alu_req_t            alu_req_o,
  output logic [id_isa_pkg::XLEN-1:0]      lsu_wdata_o
);

  logic [id_isa_pkg::XLEN-1:0] imm_i_type;
  logic [id_isa_pkg::XLEN-1:0] imm_s_type;
  logic [id_isa_pkg::XLEN-1:0] imm_b_type;
  logic [id_isa_pkg::XLEN-1:0] imm_u_type;
  logic [id_isa_pkg::XLEN-1:0] imm;

  //////////////////////////////
  // Immediates
  //////////////////////////////

  assign imm_i_type = {{20{instr_i.r_fmt.funct7[6]}}, instr_i.r_fmt.funct7, instr_i.r_fmt.rs2};
  assign imm_s_type = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
  // imm[12] imm[11] imm[10:5] imm[4:1] and a zero lsb
  assign imm_b_type = {{19{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi[6],
                       instr_i.s_fmt.imm_lo[0], instr_i.s_fmt.imm_hi[5:0],
                       instr_i.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_u_type = {instr_i.r_fmt.funct7, instr_i.r_fmt.rs2, instr_i.r_fmt.rs1,
                       instr_i.r_fmt.funct3, 12'b0};

  always_comb begin
    case (dec_i.imm_sel)
      id_ctrl_pkg::IMM_S: imm = imm_s_type;
      id_ctrl_pkg::IMM_B: imm = imm_b_type;
      id_ctrl_pkg::IMM_U: imm = imm_u_type;
      default:            imm = imm_i_type;
    endcase
  end

  //////////////////////////////
  // Operands
  //////////////////////////////

  always_comb begin
    case (dec_i.op_a_sel)
      id_ctrl_pkg::OP_A_PC:   alu_req_o.operand_a = pc_i;
      id_ctrl_pkg::OP_A_ZERO: alu_req_o.operand_a = '0;
      default:                alu_req_o.operand_a = rdata_a_i;
    endcase
  end

  assign alu_req_o.operand_b = (dec_i.op_b_sel == id_ctrl_pkg::OP_B_IMM) ? imm : rdata_b_i;
  assign alu_req_o.alu_op    = dec_i.alu_op;

  // Store data is always rs2
  assign lsu_wdata_o = rdata_b_i;

endmodule

/* hdl/id_register_file.sv */
//////////////////////////////
// Flip-flop register file
// Two combinational read ports, one write port, x0 is zero
//////////////////////////////

`timescale 1ns/1ns

module id_register_file #(
  parameter int NumRegs = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [4:0]                   raddr_a_i,
  input  logic [4:0]                   raddr_b_i,
  output logic [id_isa_pkg::XLEN-1:0]  rdata_a_o,
  output logic [id_isa_pkg::XLEN-1:0]  rdata_b_o,
  input  logic [4:0]                   waddr_i,
  input  logic [id_isa_pkg::XLEN-1:0]  wdata_i,
  input  logic                         we_i
);

  localparam logic [5:0] RegLimit = 6'(NumRegs);

  logic [id_isa_pkg::XLEN-1:0] regs [1:NumRegs-1];
  logic                        a_hit;
  logic                        b_hit;
  logic                        w_hit;

  // Index 0 and indices past the file read as zero
  assign a_hit = (raddr_a_i != 5'd0) && ({1'b0, raddr_a_i} < RegLimit);
  assign b_hit = (raddr_b_i != 5'd0) && ({1'b0, raddr_b_i} < RegLimit);
  assign w_hit = we_i && (waddr_i != 5'd0) && ({1'b0, waddr_i} < RegLimit);

  assign rdata_a_o = a_hit ? regs[raddr_a_i] : '0;
  assign rdata_b_o = b_hit ? regs[raddr_b_i] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (w_hit) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

/* hdl/id_multicycle_fsm.sv */
//////////////////////////////
// ID-EX/WB control
// Stalls loads, stores and taken branches and drives write back
//////////////////////////////

`timescale 1ns/1ns

module id_multicycle_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  id_ctrl_pkg::fetch_t          fetch_i,
  input  id_ctrl_pkg::dec_t            dec_i,
  input  logic                         branch_decision_i,
  input  id_ctrl_pkg::ex_rsp_t         ex_rsp_i,
  output logic                         rf_we_o,
  output logic [id_isa_pkg::XLEN-1:0]  rf_wdata_o,
  output logic                         lsu_req_o,
  output logic                         id_ready_o,
  output logic                         pc_set_o,
  output logic                         instr_ret_o
);

  typedef enum logic {IDLE, WAIT} state_e;

  state_e state_q, state_d;
  logic   branch_set_q, branch_set_d;
  logic   mc_done_q, mc_done_d;
  logic   instr_new;
  logic   instr_executing;
  logic   mc_start;
  logic   mc_end;
  logic   we_wb;

  assign instr_new       = fetch_i.valid & fetch_i.instr_new;
  // Still working on the held instruction
  assign instr_executing = instr_new | ~mc_done_q;
  assign mc_start        = instr_new & (dec_i.data_req | (dec_i.branch & branch_decision_i));
  // LSU ops end on lsu_valid, branches on ex_valid
  assign mc_end          = dec_i.data_req ? ex_rsp_i.lsu_valid : ex_rsp_i.ex_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      branch_set_q <= 1'b0;
      mc_done_q    <= 1'b1;
    end else begin
      state_q      <= state_d;
      branch_set_q <= branch_set_d;
      mc_done_q    <= mc_done_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    mc_done_d    = mc_done_q;
    branch_set_d = 1'b0;
    we_wb        = 1'b0;
    instr_ret_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (mc_start) begin
          state_d      = WAIT;
          mc_done_d    = 1'b0;
          branch_set_d = dec_i.branch;
        end else if (instr_new) begin
          // Single cycle, illegal words do not retire
          instr_ret_o = ~dec_i.illegal;
        end
      end
      WAIT: begin
        if (mc_end) begin
          state_d     = IDLE;
          mc_done_d   = 1'b1;
          we_wb       = dec_i.rf_we;
          instr_ret_o = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign rf_we_o    = instr_executing & ~dec_i.illegal &
                      (dec_i.data_req ? we_wb : dec_i.rf_we);
  assign rf_wdata_o = (dec_i.wb_sel == id_ctrl_pkg::WB_LSU) ? ex_rsp_i.lsu_rdata
                                                             : ex_rsp_i.ex_result;
  // Request only in the first cycle
  assign lsu_req_o  = (state_q == IDLE) & instr_new & dec_i.data_req;
  assign id_ready_o = (state_q == IDLE) & ~mc_start;
  assign pc_set_o   = branch_set_q;

endmodule

/* hdl/id_stage.sv */
//////////////////////////////
// Decode stage top level
// Fetch in, ALU and LSU requests out
//////////////////////////////

`timescale 1ns/1ns

module id_stage #(
  parameter int NumRegs = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  id_ctrl_pkg::fetch_t    fetch_i,
  input  logic                   branch_decision_i,
  input  id_ctrl_pkg::ex_rsp_t   ex_rsp_i,
  output id_ctrl_pkg::alu_req_t  alu_req_o,
  output id_ctrl_pkg::lsu_req_t  lsu_req_o,
  output logic                   id_ready_o,
  output logic                   pc_set_o,
  output logic                   instr_ret_o,
  output logic                   illegal_insn_o
);

  id_ctrl_pkg::dec_t           dec;
  logic [id_isa_pkg::XLEN-1:0] rdata_a;
  logic [id_isa_pkg::XLEN-1:0] rdata_b;
  logic [id_isa_pkg::XLEN-1:0] rf_wdata;
  logic [id_isa_pkg::XLEN-1:0] lsu_wdata;
  logic                        rf_we;
  logic                        lsu_req;

  id_decoder #(.NumRegs(NumRegs)) decoder0 (
    .instr_i       (fetch_i.instr),
    .first_cycle_i (fetch_i.instr_new),
    .dec_o         (dec)
  );

  id_operand_mux operand_mux0 (
    .instr_i     (fetch_i.instr),
    .dec_i       (dec),
    .pc_i        (fetch_i.pc),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .alu_req_o   (alu_req_o),
    .lsu_wdata_o (lsu_wdata)
  );

  id_register_file #(.NumRegs(NumRegs)) register_file0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (dec.rd),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  id_multicycle_fsm fsm0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_i           (fetch_i),
    .dec_i             (dec),
    .branch_decision_i (branch_decision_i),
    .ex_rsp_i          (ex_rsp_i),
    .rf_we_o           (rf_we),
    .rf_wdata_o        (rf_wdata),
    .lsu_req_o         (lsu_req),
    .id_ready_o        (id_ready_o),
    .pc_set_o          (pc_set_o),
    .instr_ret_o       (instr_ret_o)
  );

  assign lsu_req_o.req   = lsu_req;
  assign lsu_req_o.we    = dec.data_we;
  assign lsu_req_o.wdata = lsu_wdata;
  assign illegal_insn_o  = dec.illegal;

endmodule

/* tests/tb_id_stage.sv */
//////////////////////////////
// Testbench for the decode stage
// Applies a table of instructions, plays fetch and execute,
// and checks the requests against a shadow register model
//////////////////////////////

`timescale 1ns/1ns

module tb_id_stage;

  // Major opcodes from the RV32I base encoding
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Cycles allowed per entry beyond its response delay
  localparam int MARGIN = 4;

  typedef enum logic [2:0] {C_REG, C_IMM, C_LUI, C_LOAD, C_STORE, C_BRANCH, C_ILL} class_e;

  typedef struct packed {
    logic [31:0]          instr;
    logic [31:0]          pc;
    logic                 taken;
    logic [7:0]           delay;
    class_e               cls;
    id_ctrl_pkg::alu_op_e op;
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  id_ctrl_pkg::fetch_t   fetch;
  logic                  branch_decision;
  id_ctrl_pkg::ex_rsp_t  ex_rsp;
  id_ctrl_pkg::alu_req_t alu_req;
  id_ctrl_pkg::lsu_req_t lsu_req;
  logic                  id_ready;
  logic                  pc_set;
  logic                  instr_ret;
  logic                  illegal_insn;

  entry_t      tbl [$];
  logic [31:0] shadow [32];
  logic [31:0] lfsr_q = 32'he619_8f81;
  int          err_count;
  int          check_count;
  int          failed_tests;
  int          cycle_count;
  int          cycle_limit;

  id_stage #(.NumRegs(32)) dut0 (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .fetch_i           (fetch),
    .branch_decision_i (branch_decision),
    .ex_rsp_i          (ex_rsp),
    .alu_req_o         (alu_req),
    .lsu_req_o         (lsu_req),
    .id_ready_o        (id_ready),
    .pc_set_o          (pc_set),
    .instr_ret_o       (instr_ret),
    .illegal_insn_o    (illegal_insn)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Random source and encoders
  //////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // pc advances by one word per entry
  task automatic add_row(input logic [31:0] instr, input logic taken, input logic [7:0] delay,
                         input class_e cls, input id_ctrl_pkg::alu_op_e op);
    entry_t e;
    e.instr = instr;
    e.pc    = 32'h0000_1000 + 32'(4 * tbl.size());
    e.taken = taken;
    e.delay = delay;
    e.cls   = cls;
    e.op    = op;
    tbl.push_back(e);
  endtask

  task automatic fill_table();
    // Write then read back with x0 staying zero
    add_row(i_word(12'h123, 5'd0, 3'd0, 5'd1, OPC_OP_IMM), 0, 0, C_IMM, id_ctrl_pkg::ALU_ADD);
    add_row(r_word(7'h00, 5'd0, 5'd1, 3'd0, 5'd2), 0, 0, C_REG, id_ctrl_pkg::ALU_ADD);
    add_row(i_word(12'h055, 5'd1, 3'd0, 5'd0, OPC_OP_IMM), 0, 0, C_IMM, id_ctrl_pkg::ALU_ADD);
    add_row(r_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd21), 0, 0, C_REG, id_ctrl_pkg::ALU_ADD);
    add_row(u_word(20'habcde, 5'd3), 0, 0, C_LUI, id_ctrl_pkg::ALU_ADD);
    // OP and OP-IMM variants
    add_row(r_word(7'h20, 5'd3, 5'd2, 3'd0, 5'd4), 0, 0, C_REG, id_ctrl_pkg::ALU_SUB);
    add_row(r_word(7'h00, 5'd3, 5'd1, 3'd4, 5'd5), 0, 0, C_REG, id_ctrl_pkg::ALU_XOR);
    add_row(r_word(7'h00, 5'd2, 5'd4, 3'd6, 5'd6), 0, 0, C_REG, id_ctrl_pkg::ALU_OR);
    add_row(r_word(7'h00, 5'd6, 5'd5, 3'd7, 5'd7), 0, 0, C_REG, id_ctrl_pkg::ALU_AND);
    add_row(r_word(7'h00, 5'd2, 5'd1, 3'd2, 5'd8), 0, 0, C_REG, id_ctrl_pkg::ALU_SLT);
    add_row(i_word(12'hff0, 5'd3, 3'd7, 5'd9, OPC_OP_IMM), 0, 0, C_IMM, id_ctrl_pkg::ALU_AND);
    add_row(i_word(12'h7ff, 5'd2, 3'd6, 5'd10, OPC_OP_IMM), 0, 0, C_IMM, id_ctrl_pkg::ALU_OR);
    add_row(i_word(12'hfff, 5'd4, 3'd4, 5'd11, OPC_OP_IMM), 0, 0, C_IMM, id_ctrl_pkg::ALU_XOR);
    add_row(i_word(12'h800, 5'd5, 3'd2, 5'd12, OPC_OP_IMM), 0, 0, C_IMM, id_ctrl_pkg::ALU_SLT);
    // Stores and loads with load delays drawn up to the given bound
    add_row(s_word(12'h008, 5'd3, 5'd1), 0, 3, C_STORE, id_ctrl_pkg::ALU_ADD);
    add_row(s_word(12'hffc, 5'd7, 5'd2), 0, 1, C_STORE, id_ctrl_pkg::ALU_ADD);
    add_row(i_word(12'h010, 5'd1, 3'd2, 5'd13, OPC_LOAD), 0, 6, C_LOAD, id_ctrl_pkg::ALU_ADD);
    add_row(r_word(7'h00, 5'd3, 5'd13, 3'd0, 5'd14), 0, 0, C_REG, id_ctrl_pkg::ALU_ADD);
    add_row(i_word(12'hff8, 5'd2, 3'd2, 5'd15, OPC_LOAD), 0, 4, C_LOAD, id_ctrl_pkg::ALU_ADD);
    add_row(i_word(12'h001, 5'd15, 3'd0, 5'd16, OPC_OP_IMM), 0, 0, C_IMM, id_ctrl_pkg::ALU_ADD);
    // Branches
    add_row(b_word(13'h0010, 5'd2, 5'd1, 3'd0), 0, 0, C_BRANCH, id_ctrl_pkg::ALU_EQ);
    add_row(b_word(13'h1fe0, 5'd3, 5'd1, 3'd1), 1, 2, C_BRANCH, id_ctrl_pkg::ALU_NE);
    add_row(b_word(13'h0ffe, 5'd0, 5'd0, 3'd0), 1, 1, C_BRANCH, id_ctrl_pkg::ALU_EQ);
    add_row(b_word(13'h0008, 5'd4, 5'd4, 3'd1), 0, 0, C_BRANCH, id_ctrl_pkg::ALU_NE);
    // Illegal words each followed by a read of its rd
    add_row(r_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd5), 0, 0, C_ILL, id_ctrl_pkg::ALU_ADD);
    add_row(r_word(7'h00, 5'd0, 5'd5, 3'd0, 5'd17), 0, 0, C_REG, id_ctrl_pkg::ALU_ADD);
    add_row(i_word(12'h100, 5'd0, 3'd0, 5'd6, OPC_JAL), 0, 0, C_ILL, id_ctrl_pkg::ALU_ADD);
    add_row(r_word(7'h00, 5'd0, 5'd6, 3'd0, 5'd18), 0, 0, C_REG, id_ctrl_pkg::ALU_ADD);
    add_row(i_word(12'h003, 5'd7, 3'd1, 5'd7, OPC_OP_IMM), 0, 0, C_ILL, id_ctrl_pkg::ALU_ADD);
    add_row(r_word(7'h00, 5'd0, 5'd7, 3'd0, 5'd19), 0, 0, C_REG, id_ctrl_pkg::ALU_ADD);
    add_row(i_word(12'h000, 5'd1, 3'd0, 5'd8, OPC_LOAD), 0, 0, C_ILL, id_ctrl_pkg::ALU_ADD);
    add_row(r_word(7'h00, 5'd0, 5'd8, 3'd0, 5'd20), 0, 0, C_REG, id_ctrl_pkg::ALU_ADD);
  endtask

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  // Branch targets replace the compare operands after the first cycle
  function automatic id_ctrl_pkg::alu_req_t expected_alu(input entry_t e, input logic first);
    id_ctrl_pkg::alu_req_t r;
    logic [31:0]           w;
    w           = e.instr;
    r.alu_op    = e.op;
    r.operand_a = shadow[w[19:15]];
    r.operand_b = shadow[w[24:20]];
    case (e.cls)
      C_IMM, C_LOAD: r.operand_b = {{20{w[31]}}, w[31:20]};
      C_STORE:       r.operand_b = {{20{w[31]}}, w[31:25], w[11:7]};
      C_LUI: begin
        r.operand_a = '0;
        r.operand_b = {w[31:12], 12'h000};
      end
      C_BRANCH: begin
        if (!first) begin
          r.alu_op    = id_ctrl_pkg::ALU_ADD;
          r.operand_a = e.pc;
          r.operand_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      default: ;
    endcase
    return r;
  endfunction

  task automatic check_alu(input string what, input id_ctrl_pkg::alu_req_t got,
                           input id_ctrl_pkg::alu_req_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error @ %0t: %s op %0d a %h b %h, expected op %0d a %h b %h", $time, what,
               got.alu_op, got.operand_a, got.operand_b, exp.alu_op, exp.operand_a,
               exp.operand_b);
    end
  endtask

  task automatic check_lsu(input string what, input id_ctrl_pkg::lsu_req_t got,
                           input id_ctrl_pkg::lsu_req_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error @ %0t: %s req %b we %b wdata %h, expected req %b we %b wdata %h",
               $time, what, got.req, got.we, got.wdata, exp.req, exp.we, exp.wdata);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic run_entry(input int idx);
    entry_t                e;
    class_e                cls;
    int                    errs_before;
    int                    dly;
    logic                  is_lsu;
    logic                  multi;
    logic [31:0]           rsp;
    logic [31:0]           ld_data;
    id_ctrl_pkg::lsu_req_t exp_lsu;
    e             = tbl[idx];
    cls           = e.cls;
    errs_before   = err_count;
    is_lsu        = (cls == C_LOAD) || (cls == C_STORE);
    multi         = is_lsu || (cls == C_BRANCH && e.taken);
    rsp           = draw_bits(32);
    ld_data       = draw_bits(32);
    dly           = (cls == C_LOAD) ? 1 + int'(draw_bits(3)) % int'(e.delay) : int'(e.delay);
    exp_lsu.req   = is_lsu;
    exp_lsu.we    = (cls == C_STORE);
    exp_lsu.wdata = shadow[e.instr[24:20]];

    // First cycle of the instruction
    @(posedge clk);
    fetch.valid      <= 1'b1;
    fetch.instr_new  <= 1'b1;
    fetch.pc         <= e.pc;
    fetch.instr      <= e.instr;
    branch_decision  <= e.taken;
    ex_rsp.ex_result <= rsp;
    @(negedge clk);
    check_flag("illegal_insn", illegal_insn, cls == C_ILL);
    check_flag("id_ready", id_ready, !multi);
    check_flag("instr_ret", instr_ret, !multi && cls != C_ILL);
    check_flag("pc_set", pc_set, 1'b0);
    check_lsu("lsu_req", lsu_req, exp_lsu);
    if (cls != C_ILL) begin
      check_alu("alu_req", alu_req, expected_alu(e, 1'b1));
    end

    @(posedge clk);
    fetch.instr_new <= 1'b0;
    exp_lsu.req = 1'b0;
    if (multi) begin
      // Held in WAIT until the response arrives
      for (int c = 1; c <= dly; c++) begin
        if (c == dly) begin
          if (is_lsu) begin
            ex_rsp.lsu_valid <= 1'b1;
            ex_rsp.lsu_rdata <= ld_data;
          end else begin
            ex_rsp.ex_valid <= 1'b1;
          end
        end
        @(negedge clk);
        check_flag("id_ready in wait", id_ready, 1'b0);
        check_flag("instr_ret in wait", instr_ret, c == dly);
        check_flag("pc_set in wait", pc_set, cls == C_BRANCH && c == 1);
        check_lsu("lsu_req in wait", lsu_req, exp_lsu);
        check_alu("alu_req in wait", alu_req, expected_alu(e, 1'b0));
        @(posedge clk);
      end
      ex_rsp.lsu_valid <= 1'b0;
      ex_rsp.ex_valid  <= 1'b0;
    end
    fetch.valid     <= 1'b0;
    branch_decision <= 1'b0;
    if ((cls inside {C_REG, C_IMM, C_LUI, C_LOAD}) && e.instr[11:7] != 5'd0) begin
      shadow[e.instr[11:7]] = (cls == C_LOAD) ? ld_data : rsp;
    end
    if (multi) begin
      @(negedge clk);
      while (!id_ready) begin
        @(negedge clk);
      end
    end else begin
      // A single cycle instruction never sets the pc
      @(negedge clk);
      check_flag("pc_set after", pc_set, 1'b0);
    end

    if (err_count != errs_before) begin
      failed_tests++;
    end
    $display("test %0d %s: %s", idx, cls.name(), (err_count == errs_before) ? "ok" : "mismatch");
  endtask

  //////////////////////////////
  // Run
  //////////////////////////////

  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the decode stage never finished", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rst_n           = 1'b0;
    fetch           = '0;
    branch_decision = 1'b0;
    ex_rsp          = '0;
    err_count       = 0;
    check_count     = 0;
    failed_tests    = 0;
    cycle_count     = 0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    fill_table();
    cycle_limit = 8;
    foreach (tbl[i]) begin
      cycle_limit += int'(tbl[i].delay) + MARGIN;
    end

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tbl[i]) begin
      run_entry(i);
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tbl.size(), failed_tests,
             check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
hdl/id_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_mux.sv
hdl/id_register_file.sv
hdl/id_multicycle_fsm.sv
hdl/id_stage.sv
tests/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - files:
      - hdl/id_isa_pkg.sv
      - hdl/id_ctrl_pkg.sv
      - hdl/id_decoder.sv
      - hdl/id_operand_mux.sv
      - hdl/id_register_file.sv
      - hdl/id_multicycle_fsm.sv
      - hdl/id_stage.sv
  - target: test
    files:
      - tests/tb_id_stage.sv
